// ==== dmem.f ====
+incdir+hdl
hdl/dmem_pkg.sv
hdl/mem_req_if.sv
hdl/dmem_apb_front.sv
hdl/dmem_store_merge.sv
hdl/dmem_load_extract.sv
hdl/dmem_array.sv
hdl/dmem_top.sv
bench/dmem_checker.sv
bench/dmem_tb.sv

// ==== Bender.yml ====
package:
  name: dmem

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/dmem_pkg.sv
      - hdl/mem_req_if.sv
      - hdl/dmem_apb_front.sv
      - hdl/dmem_store_merge.sv
      - hdl/dmem_load_extract.sv
      - hdl/dmem_array.sv
      - hdl/dmem_top.sv
  - target: simulation
    include_dirs:
      - hdl
    files:
      - bench/dmem_checker.sv
      - bench/dmem_tb.sv

// ==== bench/dmem_tb.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// directed testbench for the APB data memory
// drives APB3 transfers and checks them against a byte model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_tb;
    import dmem_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int WINDOW_BYTES = `DMEM_BYTES << `DMEM_INDEX_WIDTH;
    localparam int TIMEOUT = 20;

    logic                        clk = 1'b0;
    logic                        reset;
    logic                        psel;
    logic                        penable;
    logic                        pwrite;
    logic [`DMEM_ADDR_WIDTH-1:0] paddr;
    logic [`DMEM_DATA_WIDTH-1:0] pwdata;
    access_size_e                psize;
    logic [`DMEM_DATA_WIDTH-1:0] prdata;
    logic                        pready;
    logic                        pslverr;

    // byte image of the whole window
    logic [7:0] model [WINDOW_BYTES];
    int         error_count = 0;
    int         check_count = 0;
    int         assert_fails;
    integer     seed = 33184;

    dmem_top dmem_top_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .psize   (psize),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    bind dmem_apb_front dmem_checker dmem_checker_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pready  (pready),
        .pslverr (pslverr),
        .wr_en   (req.wr_en),
        .rd_en   (req.rd_en)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] make_addr(input int index, input int offset);
        dmem_addr_u a;
        a.raw = `DMEM_BASE_ADDR;
        a.fields.index = index;
        a.fields.offset = offset;
        return a.raw;
    endfunction

    // zero-extended lane straight from the byte image
    function automatic logic [63:0] model_load(input logic [31:0] addr, input access_size_e size);
        logic [63:0] value;
        int          base;
        value = '0;
        base = addr - `DMEM_BASE_ADDR;
        for (int b = 0; b < (1 << size); b++) begin
            value[8*b +: 8] = model[base + b];
        end
        return value;
    endfunction

    task automatic apb_transfer(input logic write, input logic [31:0] addr,
            input logic [63:0] data, input access_size_e size,
            output logic [63:0] rdata, output logic err, output int waits);
        int   cycles;
        logic done;
        cycles = 0;
        done = 1'b0;
        waits = 0;
        @(negedge clk);
        psel = 1'b1;
        penable = 1'b0;
        pwrite = write;
        paddr = addr;
        pwdata = data;
        psize = size;
        @(negedge clk);
        penable = 1'b1;
        while (!done) begin
            // sample mid cycle before the rising edge
            #1;
            if (pready) begin
                rdata = prdata;
                err = pslverr;
                waits = cycles;
                done = 1'b1;
                @(posedge clk);
            end else if (cycles == TIMEOUT) begin
                $display("timeout: no pready for the access at %h", addr);
                $display("Test failures found");
                $finish;
            end else begin
                cycles++;
                @(negedge clk);
            end
        end
        @(negedge clk);
        psel = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [31:0] addr, input logic [63:0] data,
            input access_size_e size, input logic exp_err);
        logic [63:0] rdata;
        logic        err;
        int          waits;
        int          base;
        base = addr - `DMEM_BASE_ADDR;
        apb_transfer(1'b1, addr, data, size, rdata, err, waits);
        check_count += 2;
        assert (err == exp_err) else begin
            error_count++;
            $display("FAILED pslverr on write %h: got %h expected %h", addr, err, exp_err);
        end
        // writes and errors both answer in the first access cycle
        assert (waits == 0) else begin
            error_count++;
            $display("FAILED pready wait states on write %h: got %h expected %h",
                addr, waits, 0);
        end
        if (!exp_err) begin
            for (int b = 0; b < (1 << size); b++) begin
                model[base + b] = data[8*b +: 8];
            end
        end
    endtask

    task automatic apb_read(input logic [31:0] addr, input access_size_e size,
            input logic exp_err);
        logic [63:0] rdata;
        logic [63:0] expected;
        logic        err;
        int          waits;
        int          exp_waits;
        if (exp_err) begin
            expected = '0;
            exp_waits = 0;
        end else begin
            expected = model_load(addr, size);
            // one wait state while the row is registered
            exp_waits = 1;
        end
        apb_transfer(1'b0, addr, '0, size, rdata, err, waits);
        check_count += 3;
        assert (err == exp_err) else begin
            error_count++;
            $display("FAILED pslverr on read %h: got %h expected %h", addr, err, exp_err);
        end
        assert (rdata == expected) else begin
            error_count++;
            $display("FAILED prdata at %h: got %h expected %h", addr, rdata, expected);
        end
        assert (waits == exp_waits) else begin
            error_count++;
            $display("FAILED pready wait states on read %h: got %h expected %h",
                addr, waits, exp_waits);
        end
    endtask

    // every row gets a value tied to its full byte address
    task automatic fill_memory();
        logic [31:0] addr;
        for (int i = 0; i < (1 << `DMEM_INDEX_WIDTH); i++) begin
            addr = make_addr(i, 0);
            apb_write(addr, {~addr, addr}, SIZE_D, 1'b0);
        end
    endtask

    task automatic dword_round_trip();
        apb_write(make_addr(3, 0), 64'h0123_4567_89ab_cdef, SIZE_D, 1'b0);
        apb_write(make_addr(17, 0), 64'hffff_ffff_ffff_ffff, SIZE_D, 1'b0);
        apb_write(make_addr(200, 0), 64'hdead_beef_cafe_f00d, SIZE_D, 1'b0);
        apb_read(make_addr(3, 0), SIZE_D, 1'b0);
        apb_read(make_addr(17, 0), SIZE_D, 1'b0);
        apb_read(make_addr(200, 0), SIZE_D, 1'b0);
    endtask

    task automatic narrow_stores();
        apb_write(make_addr(5, 1), 64'h1111_1111_1111_11a5, SIZE_B, 1'b0);
        apb_write(make_addr(5, 2), 64'h2222_2222_2222_beef, SIZE_H, 1'b0);
        apb_write(make_addr(5, 4), 64'h3333_3333_1234_5678, SIZE_W, 1'b0);
        apb_read(make_addr(5, 0), SIZE_D, 1'b0);
        apb_write(make_addr(5, 7), 64'h0000_0000_0000_0042, SIZE_B, 1'b0);
        apb_read(make_addr(5, 0), SIZE_D, 1'b0);
    endtask

    task automatic narrow_loads();
        for (int off = 0; off < 8; off++) begin
            apb_read(make_addr(5, off), SIZE_B, 1'b0);
        end
        for (int off = 0; off < 8; off += 2) begin
            apb_read(make_addr(5, off), SIZE_H, 1'b0);
        end
        apb_read(make_addr(5, 0), SIZE_W, 1'b0);
        apb_read(make_addr(5, 4), SIZE_W, 1'b0);
    endtask

    task automatic misaligned_accesses();
        apb_write(make_addr(9, 1), 64'h0000_0000_0000_ffff, SIZE_H, 1'b1);
        apb_write(make_addr(9, 2), 64'h0000_0000_ffff_ffff, SIZE_W, 1'b1);
        apb_write(make_addr(9, 4), 64'hffff_ffff_ffff_ffff, SIZE_D, 1'b1);
        apb_read(make_addr(9, 3), SIZE_H, 1'b1);
        apb_read(make_addr(9, 0), SIZE_D, 1'b0);
    endtask

    task automatic window_bounds();
        apb_write(`DMEM_BASE_ADDR - 8, 64'h5555_5555_5555_5555, SIZE_D, 1'b1);
        apb_read(`DMEM_BASE_ADDR - 8, SIZE_D, 1'b1);
        apb_write(`DMEM_BASE_ADDR + WINDOW_BYTES, 64'h5555, SIZE_H, 1'b1);
        apb_read(`DMEM_BASE_ADDR + WINDOW_BYTES, SIZE_B, 1'b1);
    endtask

    task automatic random_mix();
        access_size_e size;
        int           index;
        int           offset;
        logic [63:0]  data;
        for (int i = 0; i < 60; i++) begin
            size = access_size_e'($random(seed) & 3);
            index = $random(seed) & 8'hff;
            // drop offset bits below the access size so it stays aligned
            offset = $random(seed) & 7 & ~((1 << size) - 1);
            data = {$random(seed), $random(seed)};
            if ($random(seed) & 1) begin
                apb_write(make_addr(index, offset), data, size, 1'b0);
            end else begin
                apb_read(make_addr(index, offset), size, 1'b0);
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        psel = 1'b0;
        penable = 1'b0;
        pwrite = 1'b0;
        paddr = '0;
        pwdata = '0;
        psize = SIZE_B;
        repeat (8) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;
        fill_memory();
        dword_round_trip();
        narrow_stores();
        narrow_loads();
        misaligned_accesses();
        window_bounds();
        random_mix();
        assert_fails = dmem_top_inst.dmem_apb_front_inst.dmem_checker_inst.fail_count;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
            check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// ==== bench/dmem_checker.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB3 protocol assertions for the data memory front
// bound into the front from the testbench
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module dmem_checker (
    input logic clk,
    input logic reset,
    input logic psel,
    input logic penable,
    input logic pready,
    input logic pslverr,
    input logic wr_en,
    input logic rd_en
);

    // running count of failed properties
    int fail_count = 0;

    // ready only inside an access cycle
    ready_in_access: assert property (@(posedge clk) disable iff (reset)
        pready |-> (psel && penable))
        else begin
            $error("pready high outside an access cycle");
            fail_count++;
        end

    error_with_ready: assert property (@(posedge clk) disable iff (reset)
        pslverr |-> pready)
        else begin
            $error("pslverr high without pready");
            fail_count++;
        end

    // write strobe lasts one cycle and never meets a rejected access
    write_one_cycle: assert property (@(posedge clk) disable iff (reset)
        wr_en |-> (!pslverr ##1 !wr_en))
        else begin
            $error("write enable too long or raised on an error access");
            fail_count++;
        end

    read_then_ready: assert property (@(posedge clk) disable iff (reset)
        rd_en |=> pready)
        else begin
            $error("read enable not followed by pready");
            fail_count++;
        end

endmodule

// ==== hdl/dmem_top.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// data memory top level with a plain APB3 slave port
// psize rides next to the APB signals as the access width
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_top (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  logic [`DMEM_ADDR_WIDTH-1:0] paddr,
    input  logic [`DMEM_DATA_WIDTH-1:0] pwdata,
    input  dmem_pkg::access_size_e      psize,
    output logic [`DMEM_DATA_WIDTH-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr
);

    logic [`DMEM_BYTES-1:0]      wr_be;
    logic [`DMEM_DATA_WIDTH-1:0] wr_data;
    logic [`DMEM_DATA_WIDTH-1:0] row;

    mem_req_if req ();

    dmem_apb_front dmem_apb_front_inst (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .psize   (psize),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr),
        .req     (req.front)
    );

    dmem_store_merge dmem_store_merge_inst (
        .req     (req.lane),
        .wr_be   (wr_be),
        .wr_data (wr_data)
    );

    dmem_load_extract dmem_load_extract_inst (
        .req (req.lane),
        .row (row)
    );

    // enables and row index come straight from the request bundle
    dmem_array dmem_array_inst (
        .clk     (clk),
        .wr_en   (req.wr_en),
        .rd_en   (req.rd_en),
        .index   (req.index),
        .wr_be   (wr_be),
        .wr_data (wr_data),
        .row     (row)
    );

endmodule

// ==== hdl/dmem_array.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// doubleword storage array
// byte-enabled writes and a registered read port
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_array (
    input  logic                         clk,
    input  logic                         wr_en,
    input  logic                         rd_en,
    input  logic [`DMEM_INDEX_WIDTH-1:0] index,
    input  logic [`DMEM_BYTES-1:0]       wr_be,
    input  logic [`DMEM_DATA_WIDTH-1:0]  wr_data,
    output logic [`DMEM_DATA_WIDTH-1:0]  row
);

    localparam int DEPTH = 1 << `DMEM_INDEX_WIDTH;

    logic [`DMEM_DATA_WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            for (int b = 0; b < `DMEM_BYTES; b++) begin
                if (wr_be[b]) begin
                    mem[index][8*b +: 8] <= wr_data[8*b +: 8];
                end
            end
        end
        // output register holds until the next read
        if (rd_en) begin
            row <= mem[index];
        end
    end

endmodule

// ==== hdl/dmem_load_extract.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// load lane extractor
// picks the addressed lane from the registered row and
// zero-extends it to a full doubleword
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_load_extract (
    mem_req_if.lane                    req,
    input logic [`DMEM_DATA_WIDTH-1:0] row
);
    import dmem_pkg::*;

    logic [`DMEM_DATA_WIDTH-1:0] shifted;
    logic [`DMEM_DATA_WIDTH-1:0] size_mask;

    // offset counts bytes, shift by eight bits each
    assign shifted = row >> {req.offset, 3'b000};

    always_comb begin
        case (req.size)
            SIZE_B:  size_mask = 64'h0000_0000_0000_00ff;
            SIZE_H:  size_mask = 64'h0000_0000_0000_ffff;
            SIZE_W:  size_mask = 64'h0000_0000_ffff_ffff;
            default: size_mask = 64'hffff_ffff_ffff_ffff;
        endcase
    end

    // no sign extension, upper bits always zero
    assign req.rdata = shifted & size_mask;

endmodule

// ==== hdl/dmem_store_merge.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// store lane merger
// turns size and offset into byte enables and spreads the
// store data so every enabled lane carries the right bytes
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_store_merge (
    mem_req_if.lane                     req,
    output logic [`DMEM_BYTES-1:0]      wr_be,
    output logic [`DMEM_DATA_WIDTH-1:0] wr_data
);
    import dmem_pkg::*;

    logic [`DMEM_BYTES-1:0] size_mask;

    // enable pattern before shifting into position
    always_comb begin
        case (req.size)
            SIZE_B:  size_mask = 8'h01;
            SIZE_H:  size_mask = 8'h03;
            SIZE_W:  size_mask = 8'h0f;
            default: size_mask = 8'hff;
        endcase
    end

    assign wr_be = size_mask << req.offset;

    // replicate the low bytes across the row,
    // alignment guarantees the shifted enables hit a copy
    always_comb begin
        case (req.size)
            SIZE_B:  wr_data = {8{req.wdata[7:0]}};
            SIZE_H:  wr_data = {4{req.wdata[15:0]}};
            SIZE_W:  wr_data = {2{req.wdata[31:0]}};
            default: wr_data = req.wdata;
        endcase
    end

endmodule

// ==== hdl/dmem_apb_front.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// APB3 slave front of the data memory
// checks window and alignment, answers errors, adds one
// wait state on reads and drives the array request
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

module dmem_apb_front (
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        psel,
    input  logic                        penable,
    input  logic                        pwrite,
    input  dmem_pkg::dmem_addr_u        paddr,
    input  logic [`DMEM_DATA_WIDTH-1:0] pwdata,
    input  dmem_pkg::access_size_e      psize,
    output logic [`DMEM_DATA_WIDTH-1:0] prdata,
    output logic                        pready,
    output logic                        pslverr,
    mem_req_if.front                    req
);
    import dmem_pkg::*;

    localparam logic [`DMEM_ADDR_WIDTH-1:0] WINDOW_END =
        `DMEM_BASE_ADDR + (`DMEM_BYTES << `DMEM_INDEX_WIDTH);

    logic access;
    logic in_window;
    logic aligned;
    logic good;
    // set in the cycle after rd_en, while the row sits in the array register
    logic read_wait;

    assign access = psel && penable;

    // window compare on the raw view
    assign in_window = (paddr.raw >= `DMEM_BASE_ADDR) && (paddr.raw < WINDOW_END);

    // natural alignment per access size
    always_comb begin
        case (psize)
            SIZE_B:  aligned = 1'b1;
            SIZE_H:  aligned = (paddr.fields.offset[0] == 1'b0);
            SIZE_W:  aligned = (paddr.fields.offset[1:0] == 2'b00);
            default: aligned = (paddr.fields.offset == '0);
        endcase
    end

    assign good = in_window && aligned;

    // errors and writes finish in the first access cycle,
    // reads need the extra cycle for the registered row
    assign pready  = access && (!good || pwrite || read_wait);
    assign pslverr = access && !good;

    assign req.wr_en = access && good && pwrite;
    assign req.rd_en = access && good && !pwrite && !read_wait;

    // address and data are held by the master across the access
    assign req.index  = paddr.fields.index;
    assign req.offset = paddr.fields.offset;
    assign req.size   = psize;
    assign req.wdata  = pwdata;

    always_ff @(posedge clk) begin
        if (reset) begin
            read_wait <= 1'b0;
        end else begin
            read_wait <= req.rd_en;
        end
    end

    // bus reads zero unless a good read is completing
    assign prdata = (access && good && read_wait) ? req.rdata : '0;

endmodule

// ==== hdl/mem_req_if.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// request bundle from the APB front to the lane logic
// front issues enables and the held address, lanes return data
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

`include "dmem_config.svh"

interface mem_req_if;
    import dmem_pkg::*;

    logic                         rd_en;
    logic                         wr_en;
    logic [`DMEM_INDEX_WIDTH-1:0] index;
    logic [OFFSET_WIDTH-1:0]      offset;
    access_size_e                 size;
    logic [`DMEM_DATA_WIDTH-1:0]  wdata;
    // load value, already shifted and zero-extended
    logic [`DMEM_DATA_WIDTH-1:0]  rdata;

    modport front (
        output rd_en, wr_en, index, offset, size, wdata,
        input  rdata
    );

    modport lane (
        input  offset, size, wdata,
        output rdata
    );

endinterface

// ==== hdl/dmem_pkg.sv ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// types shared by the data memory RTL and its testbench
// access size encoding and the split view of an APB address
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`include "dmem_config.svh"

package dmem_pkg;

    // byte offset bits inside one row
    localparam int OFFSET_WIDTH = $clog2(`DMEM_BYTES);

    // upper address bits that select the window
    localparam int WINDOW_WIDTH = `DMEM_ADDR_WIDTH - `DMEM_INDEX_WIDTH - OFFSET_WIDTH;

    // load/store width, same order as the RISC-V funct3 low bits
    typedef enum logic [1:0] {
        SIZE_B = 2'd0,
        SIZE_H = 2'd1,
        SIZE_W = 2'd2,
        SIZE_D = 2'd3
    } access_size_e;

    typedef struct packed {
        logic [WINDOW_WIDTH-1:0]      window;
        logic [`DMEM_INDEX_WIDTH-1:0] index;
        logic [OFFSET_WIDTH-1:0]      offset;
    } dmem_addr_fields_t;

    // raw word for range compares, fields for row and lane select
    typedef union packed {
        logic [`DMEM_ADDR_WIDTH-1:0] raw;
        dmem_addr_fields_t           fields;
    } dmem_addr_u;

endpackage

// ==== hdl/dmem_config.svh ====
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// build constants for the APB data memory
// include wherever widths, depth or the window base are needed
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

`ifndef DMEM_CONFIG_SVH
`define DMEM_CONFIG_SVH

// APB address and data bus widths
`define DMEM_ADDR_WIDTH 32
`define DMEM_DATA_WIDTH 64

// 256 rows of one doubleword each, 2 KiB in total
`define DMEM_INDEX_WIDTH 8
`define DMEM_BYTES 8

// base of the memory window, aligned to the window size
`define DMEM_BASE_ADDR 32'h8000_0000

`endif
